//--- sources.f
logic/mem_pkg.sv
logic/sb_drain_if.sv
logic/store_buffer.sv
logic/dcache_data.sv
logic/load_writeback.sv
logic/mem_stage.sv
tb/mem_stage_asserts.sv
tb/mem_stage_tb.sv

//--- Makefile
SIM      := verilator
FLAGS    := --binary --assert --timing -j 0
TOP      := mem_stage_tb
FILELIST := sources.f
SOURCES  := $(shell cat $(FILELIST))
BIN      := obj_dir/V$(TOP)
LOG      := sim.log

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG) || ! grep -q "NO ERRORS" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf obj_dir $(LOG)

//--- tb/mem_stage_tb.sv
`default_nettype none

module mem_stage_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mem_pkg::*;

    localparam int DCACHE_LANES = 16;
    localparam int SB_ENTRIES   = 4;
    localparam int LANE_AW      = $clog2(DCACHE_LANES);
    localparam int MEM_BYTES    = DCACHE_LANES * 16;
    localparam int MEM_AW       = $clog2(MEM_BYTES);
    localparam int RESET_CYCLES = 10;
    localparam int PASS_N       = 8;
    localparam int SIZE_ROUNDS  = 2;
    localparam int FWD_ROUNDS   = 6;
    localparam int DRAIN_N      = SB_ENTRIES + 3;
    localparam int TEST_CYCLES  = RESET_CYCLES + PASS_N + 2 * DCACHE_LANES + 12 * SIZE_ROUNDS
                                  + 3 * FWD_ROUNDS + 2 * DRAIN_N + SB_ENTRIES + 2;

    logic                  clk_i = 1'b0;
    logic                  reset_i;
    logic [ADDR_SIZE-1:0]  memop_addr_i;
    logic [WORD_SIZE-1:0]  memop_wr_data_i;
    memop_size_e           memop_size_i;
    logic                  memop_sign_ext_i;
    logic                  memop_rd_i;
    logic                  memop_wr_i;
    logic                  rf_we_i;
    logic [REG_SIZE-1:0]   rf_waddr_i;
    logic                  tkbr_i;
    logic [WORD_SIZE-1:0]  new_pc_i;
    logic                  mmu_fill_i;
    logic [ADDR_SIZE-1:0]  mmu_addr_i;
    logic [LANE_SIZE-1:0]  mmu_lane_i;
    logic [WORD_SIZE-1:0]  op_res_o;
    logic                  rf_we_o;
    logic [REG_SIZE-1:0]   rf_waddr_o;
    logic                  tkbr_o;
    logic [WORD_SIZE-1:0]  new_pc_o;

    // Models the cache data array plus everything still buffered
    logic [7:0]                  ref_mem [MEM_BYTES];
    logic [31:0]                 lfsr = 32'hff88;
    logic [ADDR_SIZE-MEM_AW-1:0] store_hi;
    int                          errors = 0;
    int                          checks = 0;

    always #4 clk_i = ~clk_i;

    mem_stage #(
        .DCACHE_LANES (DCACHE_LANES),
        .SB_ENTRIES   (SB_ENTRIES)
    ) i_mem_stage (
        .clk_i            (clk_i),
        .reset_i          (reset_i),
        .memop_addr_i     (memop_addr_i),
        .memop_wr_data_i  (memop_wr_data_i),
        .memop_size_i     (memop_size_i),
        .memop_sign_ext_i (memop_sign_ext_i),
        .memop_rd_i       (memop_rd_i),
        .memop_wr_i       (memop_wr_i),
        .rf_we_i          (rf_we_i),
        .rf_waddr_i       (rf_waddr_i),
        .tkbr_i           (tkbr_i),
        .new_pc_i         (new_pc_i),
        .mmu_fill_i       (mmu_fill_i),
        .mmu_addr_i       (mmu_addr_i),
        .mmu_lane_i       (mmu_lane_i),
        .op_res_o         (op_res_o),
        .rf_we_o          (rf_we_o),
        .rf_waddr_o       (rf_waddr_o),
        .tkbr_o           (tkbr_o),
        .new_pc_o         (new_pc_o)
    );

    bind store_buffer mem_stage_asserts #(
        .SB_ENTRIES (SB_ENTRIES)
    ) i_asserts (
        .clk_i         (clk_i),
        .reset_i       (reset_i),
        .load_i        (load_i),
        .store_i       (store_i),
        .drain_valid_i (drain.valid),
        .drain_mask_i  (drain.mask),
        .count_i       (count)
    );

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            v    = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int mem_idx(input logic [ADDR_SIZE-1:0] addr);
        return int'(addr[MEM_AW-1:0]);
    endfunction

    function automatic logic [ADDR_SIZE-1:0] store_addr(input int word, input logic [1:0] off);
        return {store_hi, (MEM_AW - 2)'(word), off};
    endfunction

    // Naturally aligned offsets only
    function automatic logic [1:0] aligned_offset(input memop_size_e size);
        if (size == BYTE) begin
            return 2'(rand_bits(2));
        end else if (size == HALF) begin
            return {1'(rand_bits(1)), 1'b0};
        end
        return 2'b00;
    endfunction

    function automatic logic [31:0] ref_load(input logic [ADDR_SIZE-1:0] addr,
                                             input memop_size_e size, input logic sext);
        int          a;
        logic [15:0] h;
        a = mem_idx(addr);
        h = {ref_mem[a + 1], ref_mem[a]};
        if (size == BYTE) begin
            return sext ? {{24{ref_mem[a][7]}}, ref_mem[a]} : {24'h0, ref_mem[a]};
        end else if (size == HALF) begin
            return sext ? {{16{h[15]}}, h} : {16'h0, h};
        end
        return {ref_mem[a + 3], ref_mem[a + 2], h};
    endfunction

    task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Outputs of this cycle show up after the next rising edge
    task automatic finish_cycle(input logic [31:0] exp_res);
        logic                exp_we;
        logic [REG_SIZE-1:0] exp_waddr;
        logic                exp_tkbr;
        logic [31:0]         exp_pc;
        exp_we    = rf_we_i;
        exp_waddr = rf_waddr_i;
        exp_tkbr  = tkbr_i;
        exp_pc    = new_pc_i;
        @(negedge clk_i);
        check_word("op_res_o", op_res_o, exp_res);
        check_word("rf_we_o", 32'(rf_we_o), 32'(exp_we));
        check_word("rf_waddr_o", 32'(rf_waddr_o), 32'(exp_waddr));
        check_word("tkbr_o", 32'(tkbr_o), 32'(exp_tkbr));
        check_word("new_pc_o", new_pc_o, exp_pc);
        memop_rd_i   = 1'b0;
        memop_wr_i   = 1'b0;
        mmu_fill_i   = 1'b0;
        memop_addr_i = rand_bits(32);
        rf_we_i      = 1'(rand_bits(1));
        rf_waddr_i   = REG_SIZE'(rand_bits(REG_SIZE));
        tkbr_i       = 1'(rand_bits(1));
        new_pc_i     = rand_bits(32);
    endtask

    task automatic read_and_check(input logic [ADDR_SIZE-1:0] addr, input memop_size_e size,
                                  input logic sext);
        memop_rd_i       = 1'b1;
        memop_addr_i     = addr;
        memop_size_i     = size;
        memop_sign_ext_i = sext;
        finish_cycle(ref_load(addr, size, sext));
    endtask

    task automatic write_and_check(input logic [ADDR_SIZE-1:0] addr, input memop_size_e size,
                                   input logic [31:0] data);
        int a;
        int n;
        a = mem_idx(addr);
        n = (size == BYTE) ? 1 : (size == HALF) ? 2 : 4;
        for (int k = 0; k < n; k++) begin
            ref_mem[a + k] = data[8*k +: 8];
        end
        memop_wr_i      = 1'b1;
        memop_addr_i    = addr;
        memop_size_i    = size;
        memop_wr_data_i = data;
        finish_cycle(addr);
    endtask

    task automatic pass_through();
        check_word("rf_we_o", 32'(rf_we_o), 32'h0);
        check_word("tkbr_o", 32'(tkbr_o), 32'h0);
        for (int i = 0; i < PASS_N; i++) begin
            finish_cycle(memop_addr_i);
        end
    endtask

    task automatic fill_then_load();
        logic [ADDR_SIZE-1:0] a;
        int                   base;
        for (int l = 0; l < DCACHE_LANES; l++) begin
            a = rand_bits(32);
            a[4 +: LANE_AW] = LANE_AW'(l);
            mmu_fill_i = 1'b1;
            mmu_addr_i = a;
            mmu_lane_i = {rand_bits(32), rand_bits(32), rand_bits(32), rand_bits(32)};
            base = mem_idx({a[ADDR_SIZE-1:4], 4'h0});
            for (int k = 0; k < 16; k++) begin
                ref_mem[base + k] = mmu_lane_i[8*k +: 8];
            end
            finish_cycle(memop_addr_i);
        end
        for (int l = 0; l < DCACHE_LANES; l++) begin
            read_and_check({rand_bits(30), 2'b00}, WORD, 1'b0);
        end
    endtask

    task automatic load_sizes();
        logic [ADDR_SIZE-1:0] a;
        for (int r = 0; r < SIZE_ROUNDS; r++) begin
            for (int off = 0; off < 4; off++) begin
                a = {rand_bits(30), 2'(off)};
                read_and_check(a, BYTE, 1'b0);
                read_and_check(a, BYTE, 1'b1);
                if (off % 2 == 0) begin
                    read_and_check(a, HALF, 1'b0);
                    read_and_check(a, HALF, 1'b1);
                end
            end
        end
    endtask

    task automatic store_forwarding();
        int          w;
        memop_size_e size;
        for (int r = 0; r < FWD_ROUNDS; r++) begin
            w    = int'(rand_bits(MEM_AW - 2));
            size = memop_size_e'(r % 3);
            write_and_check(store_addr(w, aligned_offset(size)), size, rand_bits(32));
            write_and_check(store_addr(w, aligned_offset(BYTE)), BYTE, rand_bits(32));
            read_and_check(store_addr(w, 2'b00), WORD, 1'b0);
        end
    endtask

    // Stride 5 keeps the words distinct in the cache index space
    task automatic drain_overflow();
        int start;
        start = int'(rand_bits(MEM_AW - 2));
        for (int i = 0; i < DRAIN_N; i++) begin
            write_and_check(store_addr(start + 5 * i, 2'b00), WORD, rand_bits(32));
        end
        for (int i = 0; i < SB_ENTRIES + 2; i++) begin
            finish_cycle(memop_addr_i);
        end
        for (int i = 0; i < DRAIN_N; i++) begin
            read_and_check(store_addr(start + 5 * i, 2'b00), WORD, 1'b0);
        end
    endtask

    initial begin
        reset_i          = 1'b1;
        memop_addr_i     = '0;
        memop_wr_data_i  = '0;
        memop_size_i     = WORD;
        memop_sign_ext_i = 1'b0;
        memop_rd_i       = 1'b0;
        memop_wr_i       = 1'b0;
        // High during reset, so only the reset clears the outputs
        rf_we_i          = 1'b1;
        rf_waddr_i       = '0;
        tkbr_i           = 1'b1;
        new_pc_i         = '0;
        mmu_fill_i       = 1'b0;
        mmu_addr_i       = '0;
        mmu_lane_i       = '0;
        store_hi         = (ADDR_SIZE - MEM_AW)'(rand_bits(ADDR_SIZE - MEM_AW));
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_i = 1'b0;
        pass_through();
        fill_then_load();
        load_sizes();
        store_forwarding();
        drain_overflow();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    initial begin
        #(TEST_CYCLES * 8 + 400);
        $display("timeout: tests did not finish within %0d cycles", TEST_CYCLES);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb/mem_stage_asserts.sv
`default_nettype none

module mem_stage_asserts #(
    parameter int SB_ENTRIES = 4
) (
    input logic                                clk_i,
    input logic                                reset_i,
    input logic                                load_i,
    input logic                                store_i,
    input logic                                drain_valid_i,
    input logic [3:0]                          drain_mask_i,
    input logic [$clog2(SB_ENTRIES + 1)-1:0]   count_i
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CNT_W = $clog2(SB_ENTRIES + 1);

    // A slot that was never written carries no bytes
    a_no_drain_when_empty: assert property (@(posedge clk_i) disable iff (reset_i)
        drain_valid_i |-> drain_mask_i != 4'b0000)
        else $error("store buffer drained an entry that holds no stored bytes");

    a_count_in_range: assert property (@(posedge clk_i) disable iff (reset_i)
        count_i <= CNT_W'(SB_ENTRIES))
        else $error("store buffer holds more entries than it has");

    // Execute never issues both in one cycle
    a_no_load_with_store: assert property (@(posedge clk_i) disable iff (reset_i)
        !(load_i && store_i))
        else $error("load and store issued in the same cycle");

endmodule

`default_nettype wire

//--- logic/mem_stage.sv
`default_nettype none

module mem_stage #(
    parameter int DCACHE_LANES = 16,
    parameter int SB_ENTRIES   = 4
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    // From execute
    input  logic [mem_pkg::ADDR_SIZE-1:0] memop_addr_i,
    input  logic [mem_pkg::WORD_SIZE-1:0] memop_wr_data_i,
    input  mem_pkg::memop_size_e          memop_size_i,
    input  logic                          memop_sign_ext_i,
    input  logic                          memop_rd_i,
    input  logic                          memop_wr_i,
    input  logic                          rf_we_i,
    input  logic [mem_pkg::REG_SIZE-1:0]  rf_waddr_i,
    input  logic                          tkbr_i,
    input  logic [mem_pkg::WORD_SIZE-1:0] new_pc_i,
    // Lane fill from the MMU
    input  logic                          mmu_fill_i,
    input  logic [mem_pkg::ADDR_SIZE-1:0] mmu_addr_i,
    input  logic [mem_pkg::LANE_SIZE-1:0] mmu_lane_i,
    // To write-back
    output logic [mem_pkg::WORD_SIZE-1:0] op_res_o,
    output logic                          rf_we_o,
    output logic [mem_pkg::REG_SIZE-1:0]  rf_waddr_o,
    output logic                          tkbr_o,
    output logic [mem_pkg::WORD_SIZE-1:0] new_pc_o
);
    import mem_pkg::*;

    logic [WORD_SIZE-1:0] cache_rd_data;
    logic [WORD_SIZE-1:0] fwd_data;
    logic [3:0]           fwd_mask;

    sb_drain_if drain_if ();

    store_buffer #(
        .SB_ENTRIES (SB_ENTRIES)
    ) i_store_buffer (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .store_i    (memop_wr_i),
        .load_i     (memop_rd_i),
        .addr_i     (memop_addr_i),
        .size_i     (memop_size_i),
        .wr_data_i  (memop_wr_data_i),
        .fwd_data_o (fwd_data),
        .fwd_mask_o (fwd_mask),
        .drain      (drain_if.source)
    );

    dcache_data #(
        .DCACHE_LANES (DCACHE_LANES)
    ) i_dcache_data (
        .clk_i       (clk_i),
        .fill_i      (mmu_fill_i),
        .fill_addr_i (mmu_addr_i),
        .fill_lane_i (mmu_lane_i),
        .rd_addr_i   (memop_addr_i),
        .rd_data_o   (cache_rd_data),
        .drain       (drain_if.sink)
    );

    load_writeback i_load_writeback (
        .clk_i        (clk_i),
        .reset_i      (reset_i),
        .load_i       (memop_rd_i),
        .addr_i       (memop_addr_i),
        .size_i       (memop_size_i),
        .sign_ext_i   (memop_sign_ext_i),
        .cache_data_i (cache_rd_data),
        .fwd_data_i   (fwd_data),
        .fwd_mask_i   (fwd_mask),
        .rf_we_i      (rf_we_i),
        .rf_waddr_i   (rf_waddr_i),
        .tkbr_i       (tkbr_i),
        .new_pc_i     (new_pc_i),
        .op_res_o     (op_res_o),
        .rf_we_o      (rf_we_o),
        .rf_waddr_o   (rf_waddr_o),
        .tkbr_o       (tkbr_o),
        .new_pc_o     (new_pc_o)
    );

endmodule

`default_nettype wire

//--- logic/load_writeback.sv
`default_nettype none

module load_writeback (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          load_i,
    input  logic [mem_pkg::ADDR_SIZE-1:0] addr_i,
    input  mem_pkg::memop_size_e          size_i,
    input  logic                          sign_ext_i,
    input  logic [mem_pkg::WORD_SIZE-1:0] cache_data_i,
    input  logic [mem_pkg::WORD_SIZE-1:0] fwd_data_i,
    input  logic [3:0]                    fwd_mask_i,
    input  logic                          rf_we_i,
    input  logic [mem_pkg::REG_SIZE-1:0]  rf_waddr_i,
    input  logic                          tkbr_i,
    input  logic [mem_pkg::WORD_SIZE-1:0] new_pc_i,
    output logic [mem_pkg::WORD_SIZE-1:0] op_res_o,
    output logic                          rf_we_o,
    output logic [mem_pkg::REG_SIZE-1:0]  rf_waddr_o,
    output logic                          tkbr_o,
    output logic [mem_pkg::WORD_SIZE-1:0] new_pc_o
);
    import mem_pkg::*;

    logic [WORD_SIZE-1:0] merged;
    logic [WORD_SIZE-1:0] shifted;
    logic [WORD_SIZE-1:0] load_val;

    always_comb begin
        // Buffered bytes are newer than the cache
        for (int b = 0; b < 4; b++) begin
            merged[8*b +: 8] = fwd_mask_i[b] ? fwd_data_i[8*b +: 8] : cache_data_i[8*b +: 8];
        end
        shifted = merged >> {addr_i[1:0], 3'b000};
        unique case (size_i)
            BYTE:    load_val = {{(WORD_SIZE-8){sign_ext_i & shifted[7]}}, shifted[7:0]};
            HALF:    load_val = {{(WORD_SIZE-16){sign_ext_i & shifted[15]}}, shifted[15:0]};
            default: load_val = shifted;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rf_we_o <= 1'b0;
            tkbr_o  <= 1'b0;
        end else begin
            rf_we_o <= rf_we_i;
            tkbr_o  <= tkbr_i;
        end
    end

    always_ff @(posedge clk_i) begin
        op_res_o   <= load_i ? load_val : addr_i;
        rf_waddr_o <= rf_waddr_i;
        new_pc_o   <= new_pc_i;
    end

endmodule

`default_nettype wire

//--- logic/dcache_data.sv
`default_nettype none

module dcache_data #(
    parameter int DCACHE_LANES = 16
) (
    input  logic                          clk_i,
    input  logic                          fill_i,
    input  logic [mem_pkg::ADDR_SIZE-1:0] fill_addr_i,
    input  mem_pkg::dcache_lane_u         fill_lane_i,
    input  logic [mem_pkg::ADDR_SIZE-1:0] rd_addr_i,
    output logic [mem_pkg::WORD_SIZE-1:0] rd_data_o,
    sb_drain_if.sink                      drain
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(DCACHE_LANES);
    localparam int WPL   = LANE_SIZE / WORD_SIZE;

    dcache_lane_u lanes [DCACHE_LANES];

    logic [IDX_W-1:0] fill_idx;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] dr_idx;
    logic [1:0]       dr_word;

    // Lane index sits above the 16-byte lane offset
    assign fill_idx = fill_addr_i[4 +: IDX_W];
    assign rd_idx   = rd_addr_i[4 +: IDX_W];

    // Drain address is already a word address
    assign dr_idx  = drain.addr[4 +: IDX_W];
    assign dr_word = drain.addr[3:2];

    assign rd_data_o = lanes[rd_idx].words[rd_addr_i[3:2]];

    always_ff @(posedge clk_i) begin
        if (fill_i) begin
            for (int w = 0; w < WPL; w++) begin
                lanes[fill_idx].words[w] <= fill_lane_i.words[w];
            end
        end
        // Later assignment wins, so drained bytes override the fill
        if (drain.valid) begin
            for (int b = 0; b < 4; b++) begin
                if (drain.mask[b]) begin
                    lanes[dr_idx].bytes[{dr_word, 2'(b)}] <= drain.data[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/store_buffer.sv
`default_nettype none

module store_buffer #(
    parameter int SB_ENTRIES = 4
) (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          store_i,
    input  logic                          load_i,
    input  logic [mem_pkg::ADDR_SIZE-1:0] addr_i,
    input  mem_pkg::memop_size_e          size_i,
    input  logic [mem_pkg::WORD_SIZE-1:0] wr_data_i,
    output logic [mem_pkg::WORD_SIZE-1:0] fwd_data_o,
    output logic [3:0]                    fwd_mask_o,
    sb_drain_if.source                    drain
);
    import mem_pkg::*;

    localparam int IDX_W = $clog2(SB_ENTRIES);
    localparam int CNT_W = $clog2(SB_ENTRIES + 1);

    // Entry 0 is the oldest, valid entries are packed from 0 up
    logic [ADDR_SIZE-1:2] ent_addr [SB_ENTRIES];
    logic [WORD_SIZE-1:0] ent_data [SB_ENTRIES];
    logic [3:0]           ent_mask [SB_ENTRIES];
    logic [CNT_W-1:0]     count;

    logic [3:0]           st_mask;
    logic [WORD_SIZE-1:0] st_data;
    logic                 hit;
    logic [IDX_W-1:0]     hit_idx;
    logic                 full;
    logic                 alloc;
    logic [CNT_W-1:0]     tail;

    // Place store bytes on their lanes within the word
    always_comb begin
        unique case (size_i)
            BYTE:    st_mask = 4'b0001 << addr_i[1:0];
            HALF:    st_mask = 4'b0011 << addr_i[1:0];
            default: st_mask = 4'b1111;
        endcase
        st_data = wr_data_i << {addr_i[1:0], 3'b000};
    end

    // At most one entry per word, so a single match
    always_comb begin
        hit     = 1'b0;
        hit_idx = '0;
        for (int i = 0; i < SB_ENTRIES; i++) begin
            if (CNT_W'(i) < count && ent_addr[i] == addr_i[ADDR_SIZE-1:2]) begin
                hit     = 1'b1;
                hit_idx = IDX_W'(i);
            end
        end
    end

    assign full  = (count == CNT_W'(SB_ENTRIES));
    assign alloc = store_i && !hit;
    assign tail  = count - CNT_W'(drain.valid);

    // Drain when idle, or to make room for a new word
    assign drain.valid = (count != '0) && ((!load_i && !store_i) || (alloc && full));
    assign drain.addr  = ent_addr[0];
    assign drain.data  = ent_data[0];
    assign drain.mask  = ent_mask[0];

    assign fwd_data_o = ent_data[hit_idx];
    assign fwd_mask_o = (load_i && hit) ? ent_mask[hit_idx] : 4'b0000;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count <= '0;
        end else begin
            count <= count - CNT_W'(drain.valid) + CNT_W'(alloc);
        end
    end

    always_ff @(posedge clk_i) begin
        if (drain.valid) begin
            for (int i = 0; i < SB_ENTRIES - 1; i++) begin
                ent_addr[i] <= ent_addr[i + 1];
                ent_data[i] <= ent_data[i + 1];
                ent_mask[i] <= ent_mask[i + 1];
            end
        end
        if (alloc) begin
            ent_addr[IDX_W'(tail)] <= addr_i[ADDR_SIZE-1:2];
            ent_data[IDX_W'(tail)] <= st_data;
            ent_mask[IDX_W'(tail)] <= st_mask;
        end else if (store_i) begin
            // Coalesce into the existing word
            for (int b = 0; b < 4; b++) begin
                if (st_mask[b]) begin
                    ent_data[hit_idx][8*b +: 8] <= st_data[8*b +: 8];
                end
            end
            ent_mask[hit_idx] <= ent_mask[hit_idx] | st_mask;
        end
    end

endmodule

`default_nettype wire

//--- logic/sb_drain_if.sv
`default_nettype none

interface sb_drain_if;
    import mem_pkg::*;

    logic                 valid;
    logic [ADDR_SIZE-1:2] addr;
    logic [WORD_SIZE-1:0] data;
    logic [3:0]           mask;

    modport source (output valid, output addr, output data, output mask);
    modport sink   (input valid, input addr, input data, input mask);

endinterface

`default_nettype wire

//--- logic/mem_pkg.sv
`default_nettype none

package mem_pkg;

    localparam int WORD_SIZE = 32;
    localparam int REG_SIZE  = 5;
    localparam int ADDR_SIZE = 32;

    // Four words per cache lane
    localparam int LANE_SIZE = 128;

    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } memop_size_e;

    // Word view for reads and fills, byte view for masked drains
    typedef union packed {
        logic [LANE_SIZE/WORD_SIZE-1:0][WORD_SIZE-1:0] words;
        logic [LANE_SIZE/8-1:0][7:0]                   bytes;
    } dcache_lane_u;

endpackage

`default_nettype wire
